/* Makefile */
VERILATOR ?= verilator
TOP       ?= rx_req_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
source/pcie_tlp_pkg.sv
source/rx_cmd_pkg.sv
source/rx_cmd_fifo.sv
source/tag_pool.sv
source/rx_credit.sv
source/mrd_splitter.sv
source/rx_req_top.sv
verif/mrd_responder.sv
verif/rx_req_tb.sv

/* source/mrd_splitter.sv */
// Splits queued commands into reads of at most MAX_RD_UNITS that stay inside one
// MAX_RD_UNITS-aligned block; MAX_RD_UNITS is a power of two >= 2, GAP_CYCLES >= 1

`timescale 1ns/1ps
`default_nettype none

module mrd_splitter #(
  parameter int MAX_RD_UNITS = 8,
  parameter int GAP_CYCLES   = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cmd_avail,
  input  rx_cmd_pkg::rx_cmd_t    head,
  output logic                   pop,
  input  pcie_tlp_pkg::tag_t     next_tag,
  input  logic                   tag_free,
  input  pcie_tlp_pkg::units_t   free_units,
  output logic                   alloc,
  output pcie_tlp_pkg::units_t   alloc_units,
  output logic                   mrd_req,
  output pcie_tlp_pkg::mrd_req_t mrd,
  input  logic                   mrd_ack,
  output logic                   idle
);
  import pcie_tlp_pkg::*;
  import rx_cmd_pkg::*;

  localparam int OFS_W = $clog2(MAX_RD_UNITS);
  localparam int GAP_W = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES) : 1;

  split_state_t     state;
  split_state_t     state_nxt;
  logic [GAP_W-1:0] gap_cnt;

  addr_t  cur_addr;
  units_t rem_units;
  units_t chunk_units;
  tag_t   req_tag;

  logic [OFS_W-1:0] unit_ofs;
  units_t           to_boundary;
  units_t           chunk_nxt;
  units_t           rem_after;
  logic             gate_open;

  // Units left before the next aligned block
  assign unit_ofs    = cur_addr[UNIT_SHIFT +: OFS_W];
  assign to_boundary = units_t'(MAX_RD_UNITS) - units_t'(unit_ofs);
  assign chunk_nxt   = (rem_units < to_boundary) ? rem_units : to_boundary;
  assign gate_open   = tag_free && (free_units >= chunk_nxt);
  assign rem_after   = rem_units - chunk_units;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:     if (cmd_avail) state_nxt = LOAD;
      LOAD:     state_nxt = CHECK;
      CHECK:    if (gate_open) state_nxt = REQ;
      REQ:      state_nxt = ACK_WAIT;
      ACK_WAIT: if (mrd_ack) state_nxt = DONE;
      DONE:     state_nxt = GAP;
      GAP:      if (gap_cnt == '0) state_nxt = NEXT;
      NEXT:     state_nxt = (rem_after != '0) ? CHECK : IDLE;
      default:  state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      gap_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == DONE) begin
        gap_cnt <= GAP_W'(GAP_CYCLES - 1);
      end else if (state == GAP && gap_cnt != '0) begin
        gap_cnt <= gap_cnt - GAP_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == LOAD) begin
      cur_addr  <= head.addr;
      rem_units <= head.units;
    end else if (state == NEXT) begin
      cur_addr  <= cur_addr + (addr_t'(chunk_units) << UNIT_SHIFT);
      rem_units <= rem_after;
    end
    // Counter only moves on alloc, so the tag seen here is the one used in REQ
    if (state == CHECK) begin
      chunk_units <= chunk_nxt;
      req_tag     <= next_tag;
    end
  end

  assign pop         = (state == LOAD);
  assign alloc       = (state == REQ);
  assign mrd_req     = (state == REQ);
  assign idle        = (state == IDLE);
  assign alloc_units = chunk_units;
  assign mrd         = '{tag: req_tag, addr: cur_addr, units: chunk_units};

  a_front_path: assert property (@(posedge clk) disable iff (rst)
    (state == IDLE && cmd_avail) |=> state == LOAD ##1 state == CHECK)
    else $error("command pickup did not go through LOAD and CHECK");

  a_req_path: assert property (@(posedge clk) disable iff (rst)
    mrd_req |-> alloc ##1 (state == ACK_WAIT && !mrd_req && !alloc))
    else $error("request not a single cycle strobe with alloc");

  a_ack_path: assert property (@(posedge clk) disable iff (rst)
    (state == ACK_WAIT && mrd_ack) |=> state == DONE ##1 state == GAP)
    else $error("ack did not lead through DONE into GAP");

  a_next_exit: assert property (@(posedge clk) disable iff (rst)
    state == NEXT |=> (state == CHECK || state == IDLE))
    else $error("illegal exit from NEXT");

  a_tag_ok: assert property (@(posedge clk) disable iff (rst)
    mrd_req |-> (mrd.tag[7:4] == TAG_PREFIX) && (mrd.tag == next_tag))
    else $error("request tag differs from the allocated tag");

  a_hold_mrd: assert property (@(posedge clk) disable iff (rst)
    state == ACK_WAIT |-> $stable(mrd))
    else $error("request fields changed before ack");

  a_gated: assert property (@(posedge clk) disable iff (rst)
    alloc |-> $past(tag_free) && ($past(free_units) >= alloc_units))
    else $error("request issued without tag or buffer space");

  a_no_x: assert property (@(posedge clk) disable iff (rst)
    mrd_req |-> !$isunknown(mrd))
    else $error("unknown request fields");

endmodule

`default_nettype wire

/* source/pcie_tlp_pkg.sv */
// Link-side types for memory-read requests and completions
// Lengths count 16-byte units and every tag carries the fixed upper nibble 0001

`default_nettype none

package pcie_tlp_pkg;

  localparam int TAG_W   = 8;
  localparam int ADDR_W  = 36;
  localparam int UNITS_W = 10;

  // Shift from a byte address to a 16-byte unit index
  localparam int UNIT_SHIFT = 4;

  // Upper tag nibble reserved for this requester
  localparam logic [3:0] TAG_PREFIX = 4'b0001;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [UNITS_W-1:0] units_t;

  // One memory read as handed to the transmit side
  typedef struct packed {
    tag_t   tag;
    addr_t  addr;
    units_t units;
  } mrd_req_t;

  // Finished completion, returns the tag and the buffer space it held
  typedef struct packed {
    tag_t   tag;
    units_t units;
  } cpl_t;

endpackage

`default_nettype wire

/* source/rx_cmd_fifo.sv */
// Command queue with no back-pressure
// The source must not push while CMD_DEPTH commands are waiting

`timescale 1ns/1ps
`default_nettype none

module rx_cmd_fifo #(
  parameter int CMD_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  rx_cmd_pkg::rx_cmd_t push_cmd,
  input  logic                pop,
  output logic                cmd_avail,
  output rx_cmd_pkg::rx_cmd_t head
);
  import rx_cmd_pkg::*;

  localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  rx_cmd_t          mem [CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Wrap also covers depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + PTR_W'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_cmd;
  end

  assign cmd_avail = (count != '0);
  assign head      = mem[rd_ptr];

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> count < CNT_W'(CMD_DEPTH))
    else $error("command pushed into a full queue");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> count != '0)
    else $error("command popped from an empty queue");

endmodule

`default_nettype wire

/* source/rx_cmd_pkg.sv */
// Host read-command types and splitter states
// Command addresses are 16-byte aligned and lengths are nonzero

`default_nettype none

package rx_cmd_pkg;

  // One host read command
  typedef struct packed {
    pcie_tlp_pkg::addr_t  addr;
    pcie_tlp_pkg::units_t units;
  } rx_cmd_t;

  typedef enum logic [2:0] {
    IDLE,      // waiting for a queued command
    LOAD,      // pop the head and latch address and length
    CHECK,     // size the chunk and wait for tag and buffer space
    REQ,       // strobe the request and allocate
    ACK_WAIT,  // hold the request until the transmit side takes it
    DONE,
    GAP,       // programmable pause between requests
    NEXT       // step to the next chunk
  } split_state_t;

endpackage

`default_nettype wire

/* source/rx_credit.sv */
// Free space of the receive buffer in 16-byte units
// RX_BUF_UNITS must fit in the 10-bit unit count

`timescale 1ns/1ps
`default_nettype none

module rx_credit #(
  parameter int RX_BUF_UNITS = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 alloc,
  input  pcie_tlp_pkg::units_t alloc_units,
  input  logic                 cpl_valid,
  input  pcie_tlp_pkg::cpl_t   cpl,
  output pcie_tlp_pkg::units_t free_units
);
  import pcie_tlp_pkg::*;

  units_t sub_units;
  units_t add_units;

  assign sub_units = alloc ? alloc_units : '0;
  assign add_units = cpl_valid ? cpl.units : '0;

  // Reserve and release can land in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      free_units <= units_t'(RX_BUF_UNITS);
    end else begin
      free_units <= free_units - sub_units + add_units;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    free_units <= units_t'(RX_BUF_UNITS))
    else $error("free units above buffer capacity");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    alloc |-> alloc_units <= free_units)
    else $error("reservation larger than free space");

endmodule

`default_nettype wire

/* source/rx_req_top.sv */
// Read-request side of the DMA engine, from host commands to memory reads
// MAX_RD_UNITS must not exceed RX_BUF_UNITS, or the splitter waits forever

`timescale 1ns/1ps
`default_nettype none

module rx_req_top #(
  parameter int CMD_DEPTH    = 4,
  parameter int MAX_RD_UNITS = 8,
  parameter int RX_BUF_UNITS = 32,
  parameter int GAP_CYCLES   = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cmd_valid,
  input  rx_cmd_pkg::rx_cmd_t    cmd,
  output logic                   mrd_req,
  output pcie_tlp_pkg::mrd_req_t mrd,
  input  logic                   mrd_ack,
  input  logic                   cpl_valid,
  input  pcie_tlp_pkg::cpl_t     cpl,
  output logic                   busy
);
  import pcie_tlp_pkg::*;
  import rx_cmd_pkg::*;

  logic    cmd_avail;
  rx_cmd_t head;
  logic    pop;
  tag_t    next_tag;
  logic    tag_free;
  units_t  free_units;
  logic    alloc;
  units_t  alloc_units;
  logic    idle;

  rx_cmd_fifo #(.CMD_DEPTH(CMD_DEPTH)) u_cmd_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_valid),
    .push_cmd  (cmd),
    .pop       (pop),
    .cmd_avail (cmd_avail),
    .head      (head)
  );

  tag_pool u_tag_pool (
    .clk       (clk),
    .rst       (rst),
    .alloc     (alloc),
    .cpl_valid (cpl_valid),
    .cpl       (cpl),
    .next_tag  (next_tag),
    .tag_free  (tag_free)
  );

  rx_credit #(.RX_BUF_UNITS(RX_BUF_UNITS)) u_rx_credit (
    .clk         (clk),
    .rst         (rst),
    .alloc       (alloc),
    .alloc_units (alloc_units),
    .cpl_valid   (cpl_valid),
    .cpl         (cpl),
    .free_units  (free_units)
  );

  mrd_splitter #(
    .MAX_RD_UNITS (MAX_RD_UNITS),
    .GAP_CYCLES   (GAP_CYCLES)
  ) u_splitter (
    .clk         (clk),
    .rst         (rst),
    .cmd_avail   (cmd_avail),
    .head        (head),
    .pop         (pop),
    .next_tag    (next_tag),
    .tag_free    (tag_free),
    .free_units  (free_units),
    .alloc       (alloc),
    .alloc_units (alloc_units),
    .mrd_req     (mrd_req),
    .mrd         (mrd),
    .mrd_ack     (mrd_ack),
    .idle        (idle)
  );

  // Outstanding completions alone do not keep the block busy
  assign busy = cmd_avail || !idle;

endmodule

`default_nettype wire

/* source/tag_pool.sv */
// Sixteen tags, handed out in order with the low nibble wrapping
// A tag is reused only after its completion, so a busy next tag stalls allocation

`timescale 1ns/1ps
`default_nettype none

module tag_pool (
  input  logic                clk,
  input  logic                rst,
  input  logic                alloc,
  input  logic                cpl_valid,
  input  pcie_tlp_pkg::cpl_t  cpl,
  output pcie_tlp_pkg::tag_t  next_tag,
  output logic                tag_free
);
  import pcie_tlp_pkg::*;

  logic [3:0]  tag_cnt;
  // One bit per low nibble, set while that tag is outstanding
  logic [15:0] outstanding;
  logic [15:0] set_mask;
  logic [15:0] clr_mask;

  assign next_tag = {TAG_PREFIX, tag_cnt};
  assign tag_free = !outstanding[tag_cnt];

  assign set_mask = alloc ? (16'd1 << tag_cnt) : 16'd0;
  assign clr_mask = cpl_valid ? (16'd1 << cpl.tag[3:0]) : 16'd0;

  // Alloc and completion in one cycle both apply and never hit the same bit
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_cnt     <= 4'd0;
      outstanding <= 16'd0;
    end else begin
      outstanding <= (outstanding & ~clr_mask) | set_mask;
      if (alloc) tag_cnt <= tag_cnt + 4'd1;
    end
  end

  a_alloc_free: assert property (@(posedge clk) disable iff (rst)
    alloc |-> tag_free)
    else $error("tag allocated while still outstanding");

  a_cpl_known: assert property (@(posedge clk) disable iff (rst)
    cpl_valid |-> (cpl.tag[7:4] == TAG_PREFIX) && outstanding[cpl.tag[3:0]])
    else $error("completion for a tag that is not outstanding");

endmodule

`default_nettype wire

/* verif/mrd_responder.sv */
// Transmit side and completer model; acks requests after a per-request delay
// Completions go out in request order, one per cpl_go pulse, only for acked tags

`timescale 1ns/1ps
`default_nettype none

module mrd_responder (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mrd_req,
  input  pcie_tlp_pkg::mrd_req_t mrd,
  input  logic [1:0]             ack_delay,
  input  logic                   cpl_go,
  output logic                   mrd_ack,
  output logic                   cpl_valid,
  output pcie_tlp_pkg::cpl_t     cpl,
  output int                     req_count,
  output logic                   overlap
);
  import pcie_tlp_pkg::*;

  mrd_req_t   req_log[$];
  logic [1:0] delay_log[$];
  int         acked = 0;
  int         wait_cnt = 0;
  int         cpl_asked = 0;
  int         cpl_sent = 0;

  initial begin
    mrd_ack   = 1'b0;
    cpl_valid = 1'b0;
    cpl       = '0;
    req_count = 0;
    overlap   = 1'b0;
  end

  // Requests are sampled where they are stable
  always @(posedge clk) begin
    if (!rst) begin
      if (mrd_req) begin
        // A new request while the previous one waits for its ack
        if (acked < req_log.size()) overlap <= 1'b1;
        req_log.push_back(mrd);
        delay_log.push_back(ack_delay);
        req_count = req_log.size();
      end
      if (cpl_go) cpl_asked++;
    end
  end

  always @(negedge clk) begin
    mrd_ack   <= 1'b0;
    cpl_valid <= 1'b0;
    if (acked < req_count) begin
      if (wait_cnt >= int'(delay_log[acked])) begin
        mrd_ack <= 1'b1;
        acked++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
      end
    end
    if (cpl_sent < cpl_asked && cpl_sent < acked) begin
      cpl_valid <= 1'b1;
      cpl       <= '{tag: req_log[cpl_sent].tag, units: req_log[cpl_sent].units};
      cpl_sent++;
    end
  end

endmodule

`default_nettype wire

/* verif/rx_req_tb.sv */
// Directed tests for the read-request side, default parameters only
// Expected chunks follow the split rule for MAX_RD_UNITS of 8

`timescale 1ns/1ps
`default_nettype none

module rx_req_tb;
  import pcie_tlp_pkg::*;
  import rx_cmd_pkg::*;

  localparam int MAX_RD = 8;
  localparam int LIMIT  = 4000;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  logic       cmd_valid = 1'b0;
  rx_cmd_t    cmd = '0;
  logic       cpl_go = 1'b0;
  logic [1:0] ack_delay = 2'd0;
  logic [5:0] lfsr = 6'd61;
  logic       mrd_req, mrd_ack, cpl_valid, busy, overlap;
  mrd_req_t   mrd;
  cpl_t       cpl;
  int         req_count;
  int         cycles = 0;
  int         checked = 0;
  int         cpl_done = 0;
  logic [3:0] exp_lo = 4'd0;

  rx_req_top uut (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .mrd_req(mrd_req), .mrd(mrd),
    .mrd_ack(mrd_ack), .cpl_valid(cpl_valid), .cpl(cpl), .busy(busy)
  );

  mrd_responder u_resp (
    .clk(clk), .rst(rst), .mrd_req(mrd_req), .mrd(mrd), .ack_delay(ack_delay),
    .cpl_go(cpl_go), .mrd_ack(mrd_ack), .cpl_valid(cpl_valid), .cpl(cpl),
    .req_count(req_count), .overlap(overlap)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // x^6 + x^5 + 1
  function automatic logic [5:0] lfsr_step(input logic [5:0] s);
    return {s[4:0], s[5] ^ s[4]};
  endfunction

  task automatic report_fail();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic compare_mrd(input string name, input mrd_req_t got, input mrd_req_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic compare_units(input string name, input units_t got, input units_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      report_fail();
    end
  endtask

  // New ack delay each cycle, two LFSR steps for two bits
  always @(negedge clk) begin
    lfsr         = lfsr_step(lfsr);
    ack_delay[0] = lfsr[0];
    lfsr         = lfsr_step(lfsr);
    ack_delay[1] = lfsr[0];
  end

  always @(posedge clk) begin
    cycles++;
    if (overlap) begin
      $display("A second request arrived before the previous one was acked");
      report_fail();
    end
    if (cycles >= LIMIT) begin
      $display("Run hit the cycle limit, the DUT stopped making progress");
      report_fail();
    end
  end

  task automatic push_cmd(input addr_t addr, input int units);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd       = '{addr: addr, units: units_t'(units)};
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // Walks the split rule and checks each chunk as it appears
  task automatic expect_cmd(input addr_t addr, input int units);
    int       rem;
    int       ofs;
    int       chunk;
    int       sum;
    mrd_req_t exp;
    rem = units;
    sum = 0;
    while (rem > 0) begin
      ofs   = int'((addr >> 4) % MAX_RD);
      chunk = (rem < MAX_RD - ofs) ? rem : MAX_RD - ofs;
      while (req_count <= checked) @(posedge clk);
      exp = '{tag: {TAG_PREFIX, exp_lo}, addr: addr, units: units_t'(chunk)};
      compare_mrd($sformatf("mrd[%0d]", checked), u_resp.req_log[checked], exp);
      checked++;
      exp_lo++;
      addr = addr + addr_t'(chunk * 16);
      rem  = rem - chunk;
      sum  = sum + chunk;
    end
    compare_units("chunk unit sum", units_t'(sum), units_t'(units));
    // Splitter still holds the last chunk
    compare_flag("busy", busy, 1'b1);
  endtask

  task automatic complete(input int n);
    repeat (n) begin
      @(negedge clk);
      cpl_go = 1'b1;
      @(negedge clk);
      cpl_go = 1'b0;
      cpl_done++;
    end
  endtask

  task automatic finish_all();
    complete(checked - cpl_done);
    while (busy) @(posedge clk);
    repeat (3) @(posedge clk);
    compare_units("free_units", uut.u_rx_credit.free_units, units_t'(32));
  endtask

  // Nothing new may appear while a resource gate is closed
  task automatic expect_stall();
    repeat (30) @(posedge clk);
    compare_units("request count", units_t'(req_count), units_t'(checked));
  endtask

  task automatic test_single();
    push_cmd(36'h100, 4);
    expect_cmd(36'h100, 4);
    finish_all();
  endtask

  task automatic test_split();
    push_cmd(36'h130, 20);
    expect_cmd(36'h130, 20);
    finish_all();
  endtask

  task automatic test_credit();
    for (int i = 0; i < 4; i++) begin
      push_cmd(addr_t'(36'h1000 + i * 128), 8);
      expect_cmd(addr_t'(36'h1000 + i * 128), 8);
    end
    push_cmd(36'h1200, 8);
    expect_stall();
    complete(1);
    expect_cmd(36'h1200, 8);
    finish_all();
  endtask

  task automatic test_tags();
    for (int i = 0; i < 16; i++) begin
      push_cmd(addr_t'(36'h2000 + i * 16), 1);
      expect_cmd(addr_t'(36'h2000 + i * 16), 1);
    end
    push_cmd(36'h2100, 1);
    expect_stall();
    compare_units("outstanding tags",
                  units_t'($countones(uut.u_tag_pool.outstanding)), units_t'(16));
    complete(1);
    expect_cmd(36'h2100, 1);
    finish_all();
  endtask

  task automatic test_queue();
    addr_t a [4];
    int    len [4];
    len  = '{10, 6, 12, 4};
    a[0] = 36'h400;
    for (int i = 1; i < 4; i++) begin
      a[i] = a[i-1] + addr_t'(len[i-1] * 16);
    end
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd       = '{addr: a[i], units: units_t'(len[i])};
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    // Each command is split on its own, in queue order
    for (int i = 0; i < 4; i++) begin
      expect_cmd(a[i], len[i]);
    end
    finish_all();
  endtask

  initial begin
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_single();
    test_split();
    test_credit();
    test_tags();
    test_queue();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
